/* hdl/vid_defines.svh */
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// Host bus and register widths
`define VID_DATA_W            16
`define VID_ADDR_W            8
`define VID_OFFS_W            4
`define VID_NUM_REGS          16

// Address decode
`define VID_BANK_SEL_BIT      7     // 0 generic, 1 tile
`define VID_UNMAP_HI          6     // Bits 6:4 must be zero
`define VID_UNMAP_LO          4

// Generic bank, read-only words
`define VID_ID                0
`define VID_OUTPUT_STATUS     1
`define VID_SCAN_X            2
`define VID_SCAN_Y            3
// Generic bank, read/write words
`define VID_SYS_CTRL          4
`define VID_MEM_BANK          5
`define VID_OUTPUT_CTRL       6
`define VID_MODE_CTRL         7
`define VID_SPRITE_Z          8
`define VID_SCROLL_X          9
`define VID_SCROLL_Y          10

// Tile bank, all read/write
`define VID_TILE_CTRL0        0
`define VID_TILE_DATA_OFFSET  1
`define VID_TILE_NOP_VALUE    2
`define VID_TILE_COLOR_KEY    3
`define VID_TILE_OFFSET_X     4
`define VID_TILE_OFFSET_Y     5

`define VID_ID_VALUE          16'hA51C
`define VID_RUN_BIT           0     // In SYS_CTRL
`define VID_STAT_VBLANK       0
`define VID_STAT_HBLANK       1

// Register map selector for the bank
`define VID_MAP_GENERIC       0
`define VID_MAP_TILE          1

// Scan geometry in clk ticks and lines
`define VID_H_TOTAL           40
`define VID_H_ACTIVE          32
`define VID_V_TOTAL           25
`define VID_V_ACTIVE          20

`endif

/* hdl/vid_reg_pkg.sv */
`default_nettype none

`include "vid_defines.svh"

package vid_reg_pkg;

  // Byte view used for byte-enabled writes
  typedef struct packed {
    logic [`VID_DATA_W/2-1:0] hi;   // be[1]
    logic [`VID_DATA_W/2-1:0] lo;   // be[0]
  } reg_bytes_t;

  // One register word, seen whole or as two bytes
  typedef union packed {
    logic [`VID_DATA_W-1:0] raw;
    reg_bytes_t             bytes;
  } reg_word_u;

  // Read-only sources from the scan logic
  typedef struct packed {
    logic [`VID_DATA_W-1:0] status;   // Bit 0 vblank, bit 1 hblank
    logic [`VID_DATA_W-1:0] scan_x;
    logic [`VID_DATA_W-1:0] scan_y;
  } vid_ro_t;

  // Full contents of one bank, indexed by offset
  typedef reg_word_u [`VID_NUM_REGS-1:0] vid_reg_file_t;

endpackage

`default_nettype wire

/* hdl/vid_bus_pkg.sv */
`default_nettype none

`include "vid_defines.svh"

package vid_bus_pkg;

  // Host access, sampled on clk when en is high
  typedef struct packed {
    logic                   en;
    logic                   rd;
    logic                   wr;
    logic [1:0]             be;
    logic [`VID_ADDR_W-1:0] addr;
    logic [`VID_DATA_W-1:0] wdata;
  } vid_host_req_t;

  typedef struct packed {
    logic                   rd_valid;   // One cycle after the read
    logic [`VID_DATA_W-1:0] rdata;
  } vid_host_rsp_t;

  // Per-bank access after decode
  typedef struct packed {
    logic                   wr_en;
    logic [1:0]             be;
    logic [`VID_OFFS_W-1:0] offset;
    logic [`VID_DATA_W-1:0] wdata;
  } vid_bank_acc_t;

endpackage

`default_nettype wire

/* hdl/vid_reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vid_defines.svh"

module vid_reg_bank
  import vid_reg_pkg::*;
  import vid_bus_pkg::*;
#(
  parameter int MAP = `VID_MAP_GENERIC
)
(
  input  wire           clk,
  input  wire           arst_n,
  input  vid_bank_acc_t acc,
  input  vid_ro_t       ro_values,
  output reg_word_u     rd_word,
  output vid_reg_file_t regs
);

  localparam logic [1:0] KIND_ZERO = 2'd0;
  localparam logic [1:0] KIND_RW   = 2'd1;
  localparam logic [1:0] KIND_RO   = 2'd2;

  // Register map: kind of each offset for this bank
  function automatic logic [1:0] reg_kind(input int unsigned offs);
    logic [1:0] kind;
    kind = KIND_ZERO;
    if (MAP == `VID_MAP_GENERIC)
    begin
      case (offs)
        `VID_ID,
        `VID_OUTPUT_STATUS,
        `VID_SCAN_X,
        `VID_SCAN_Y:        kind = KIND_RO;
        `VID_SYS_CTRL,
        `VID_MEM_BANK,
        `VID_OUTPUT_CTRL,
        `VID_MODE_CTRL,
        `VID_SPRITE_Z,
        `VID_SCROLL_X,
        `VID_SCROLL_Y:      kind = KIND_RW;
        default:            kind = KIND_ZERO;
      endcase
    end
    else
    begin
      case (offs)
        `VID_TILE_CTRL0,
        `VID_TILE_DATA_OFFSET,
        `VID_TILE_NOP_VALUE,
        `VID_TILE_COLOR_KEY,
        `VID_TILE_OFFSET_X,
        `VID_TILE_OFFSET_Y: kind = KIND_RW;
        default:            kind = KIND_ZERO;
      endcase
    end
    return kind;
  endfunction

  reg_word_u wr_word;   // Incoming data, byte view for the merge

  assign wr_word.raw = acc.wdata;

  for (genvar i = 0; i < `VID_NUM_REGS; i++)
  begin : g_word
    localparam logic [`VID_OFFS_W-1:0] OFFS = i;
    localparam logic [1:0]             KIND = reg_kind(i);

    if (KIND == KIND_RW)
    begin : g_rw
      reg_word_u q;
      logic      hit;

      assign hit = acc.wr_en && (acc.offset == OFFS);

      always_ff @(posedge clk or negedge arst_n)
      begin
        if (!arst_n)
        begin
          q <= '0;
        end
        else if (hit)
        begin
          if (acc.be[0])
            q.bytes.lo <= wr_word.bytes.lo;
          if (acc.be[1])
            q.bytes.hi <= wr_word.bytes.hi;
        end
      end

      assign regs[i] = q;
    end
    else if (KIND == KIND_RO)
    begin : g_ro
      // Only the generic map has read-only words
      case (i)
        `VID_ID:            assign regs[i].raw = `VID_ID_VALUE;
        `VID_OUTPUT_STATUS: assign regs[i].raw = ro_values.status;
        `VID_SCAN_X:        assign regs[i].raw = ro_values.scan_x;
        `VID_SCAN_Y:        assign regs[i].raw = ro_values.scan_y;
        default:            assign regs[i].raw = '0;
      endcase
    end
    else
    begin : g_zero
      assign regs[i].raw = '0;   // Unused offset
    end
  end

  // Combinational read, registered in the host port
  assign rd_word = regs[acc.offset];

endmodule

`default_nettype wire

/* hdl/vid_scan_counter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vid_defines.svh"

module vid_scan_counter
  import vid_reg_pkg::*;
(
  input  wire           clk,
  input  wire           arst_n,
  input  vid_reg_file_t gen_regs,
  output vid_ro_t       ro_values
);

  localparam int X_W = $clog2(`VID_H_TOTAL);
  localparam int Y_W = $clog2(`VID_V_TOTAL);
  localparam int DW  = `VID_DATA_W;

  localparam logic [X_W-1:0] X_LAST = X_W'(`VID_H_TOTAL - 1);
  localparam logic [Y_W-1:0] Y_LAST = Y_W'(`VID_V_TOTAL - 1);

  logic [X_W-1:0] x_q;
  logic [Y_W-1:0] y_q;
  logic           run;
  logic           hblank;
  logic           vblank;

  assign run = gen_regs[`VID_SYS_CTRL].raw[`VID_RUN_BIT];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      x_q <= '0;
      y_q <= '0;
    end
    else if (run)
    begin
      if (x_q == X_LAST)
      begin
        x_q <= '0;
        y_q <= (y_q == Y_LAST) ? '0 : y_q + 1'b1;   // Next line or frame wrap
      end
      else
      begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  // Blanking past the active area
  assign hblank = (x_q >= `VID_H_ACTIVE);
  assign vblank = (y_q >= `VID_V_ACTIVE);

  assign ro_values.status = {{(DW - 2){1'b0}}, hblank, vblank};
  assign ro_values.scan_x = DW'(x_q);
  assign ro_values.scan_y = DW'(y_q);

endmodule

`default_nettype wire

/* hdl/vid_host_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vid_defines.svh"

module vid_host_port
  import vid_reg_pkg::*;
  import vid_bus_pkg::*;
(
  input  wire           clk,
  input  wire           arst_n,
  input  vid_host_req_t host_req,
  input  reg_word_u     gen_rd_word,
  input  reg_word_u     tile_rd_word,
  output vid_host_rsp_t host_rsp,
  output vid_bank_acc_t gen_acc,
  output vid_bank_acc_t tile_acc
);

  logic                   rd_acc;
  logic                   wr_acc;
  logic                   mapped;
  logic                   tile_sel;
  logic [`VID_DATA_W-1:0] rd_mux;
  logic                   rd_valid_q;
  logic [`VID_DATA_W-1:0] rdata_q;

  // Read wins when rd and wr are both set
  assign rd_acc = host_req.en && host_req.rd;
  assign wr_acc = host_req.en && host_req.wr && !host_req.rd;

  assign mapped   = (host_req.addr[`VID_UNMAP_HI:`VID_UNMAP_LO] == '0);
  assign tile_sel = host_req.addr[`VID_BANK_SEL_BIT];

  // Same offset and data to both banks
  assign gen_acc.wr_en  = wr_acc && mapped && !tile_sel;
  assign gen_acc.be     = host_req.be;
  assign gen_acc.offset = host_req.addr[`VID_OFFS_W-1:0];
  assign gen_acc.wdata  = host_req.wdata;

  assign tile_acc.wr_en  = wr_acc && mapped && tile_sel;
  assign tile_acc.be     = host_req.be;
  assign tile_acc.offset = host_req.addr[`VID_OFFS_W-1:0];
  assign tile_acc.wdata  = host_req.wdata;

  always_comb
  begin
    if (!mapped)
      rd_mux = '0;   // Unmapped reads return zero
    else if (tile_sel)
      rd_mux = tile_rd_word.raw;
    else
      rd_mux = gen_rd_word.raw;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rd_valid_q <= 1'b0;
    else
      rd_valid_q <= rd_acc;   // Single-cycle pulse per read
  end

  // Read data holds until the next read
  always_ff @(posedge clk)
  begin
    if (rd_acc)
      rdata_q <= rd_mux;
  end

  assign host_rsp.rd_valid = rd_valid_q;
  assign host_rsp.rdata    = rdata_q;

endmodule

`default_nettype wire

/* hdl/vid_regs_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vid_defines.svh"

module vid_regs_top
  import vid_reg_pkg::*;
  import vid_bus_pkg::*;
(
  input  wire           clk,
  input  wire           arst_n,
  input  vid_host_req_t host_req,
  output vid_host_rsp_t host_rsp,
  output vid_reg_file_t gen_regs,
  output vid_reg_file_t tile_regs
);

  vid_bank_acc_t gen_acc;
  vid_bank_acc_t tile_acc;
  reg_word_u     gen_rd_word;
  reg_word_u     tile_rd_word;
  vid_ro_t       ro_values;   // Scan position and status

  vid_host_port i_vid_host_port (
    .clk          (clk),
    .arst_n       (arst_n),
    .host_req     (host_req),
    .gen_rd_word  (gen_rd_word),
    .tile_rd_word (tile_rd_word),
    .host_rsp     (host_rsp),
    .gen_acc      (gen_acc),
    .tile_acc     (tile_acc)
  );

  vid_reg_bank #(.MAP(`VID_MAP_GENERIC)) i_gen_bank (
    .clk       (clk),
    .arst_n    (arst_n),
    .acc       (gen_acc),
    .ro_values (ro_values),
    .rd_word   (gen_rd_word),
    .regs      (gen_regs)
  );

  // Tile map has no read-only words
  vid_reg_bank #(.MAP(`VID_MAP_TILE)) i_tile_bank (
    .clk       (clk),
    .arst_n    (arst_n),
    .acc       (tile_acc),
    .ro_values (ro_values),
    .rd_word   (tile_rd_word),
    .regs      (tile_regs)
  );

  vid_scan_counter i_vid_scan_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .gen_regs  (gen_regs),
    .ro_values (ro_values)
  );

endmodule

`default_nettype wire

/* verif/tb_vid_regs_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vid_defines.svh"

module tb_vid_regs_top
  import vid_reg_pkg::*;
  import vid_bus_pkg::*;
();

  localparam int FRAME    = `VID_H_TOTAL * `VID_V_TOTAL;
  localparam int WAIT_MAX = 20;

  logic          clk;
  logic          arst_n;
  vid_host_req_t host_req;
  vid_host_rsp_t host_rsp;
  vid_reg_file_t gen_regs;
  vid_reg_file_t tile_regs;

  reg_word_u   gen_mdl [`VID_NUM_REGS];
  reg_word_u   tile_mdl [`VID_NUM_REGS];
  reg_word_u   exp_val [$];   // Expected read data in issue order
  bit          exp_chk [$];   // Clear for scan words
  reg_word_u   cap_q [$];     // Scan reads, checked by the sequence
  logic        rd_pending = 1'b0;
  bit          file_chk_en = 1'b1;
  int          cycle_cnt = 0;
  int          scan_lin = 0;   // Model scan position, y * H_TOTAL + x
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  logic [31:0] lcg_state = 32'd39;

  vid_regs_top i_vid_regs_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .gen_regs  (gen_regs),
    .tile_regs (tile_regs)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    #2_000_000;
    $display("Timeout: simulation ran past its time limit");
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];   // Upper bits are the better ones
  endfunction

  function automatic bit is_rw(input logic tile, input logic [3:0] offs);
    if (tile)
      return offs <= `VID_TILE_OFFSET_Y;
    return offs >= `VID_SYS_CTRL && offs <= `VID_SCROLL_Y;
  endfunction

  function automatic bit is_scan_word(input logic [7:0] addr);
    return addr[6:4] == 3'b000 && !addr[7] && addr[3:0] >= `VID_OUTPUT_STATUS &&
           addr[3:0] <= `VID_SCAN_Y;
  endfunction

  // Expected read value; the counter sits at 0,0 whenever this is used for scan words
  function automatic reg_word_u ref_read(input logic [7:0] addr);
    reg_word_u r;
    r.raw = '0;
    if (addr[6:4] != 3'b000)
      return r;   // Unmapped
    if (addr[7])
    begin
      if (is_rw(1'b1, addr[3:0]))
        r = tile_mdl[addr[3:0]];
    end
    else if (addr[3:0] == `VID_ID)
      r.raw = `VID_ID_VALUE;
    else if (is_rw(1'b0, addr[3:0]))
      r = gen_mdl[addr[3:0]];
    return r;
  endfunction

  function automatic vid_reg_file_t expected_file(input logic tile);
    vid_reg_file_t f;
    for (int i = 0; i < `VID_NUM_REGS; i++)
      f[i] = ref_read({tile, 3'b000, 4'(i)});
    return f;
  endfunction

  function automatic reg_word_u merge_bytes(input reg_word_u old, input reg_word_u wr,
                                            input logic [1:0] be);
    reg_word_u r;
    r = old;
    if (be[0])
      r.bytes.lo = wr.bytes.lo;
    if (be[1])
      r.bytes.hi = wr.bytes.hi;
    return r;
  endfunction

  task automatic check_word(input string name, input reg_word_u got, input reg_word_u exp);
    if (got.raw !== exp.raw)
    begin
      mismatch_cnt++;
      $display("mismatch %s: got %h exp %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_file(input string name, input vid_reg_file_t got,
                            input vid_reg_file_t exp);
    for (int i = 0; i < `VID_NUM_REGS; i++)
      if (got[i].raw !== exp[i].raw)
      begin
        mismatch_cnt++;
        $display("mismatch %s[%0d]: got %h exp %h", name, i, got[i].raw, exp[i].raw);
      end
  endtask

  task automatic check_valid(input vid_host_rsp_t rsp, input logic exp);
    if (rsp.rd_valid !== exp)
    begin
      mismatch_cnt++;
      $display("mismatch rd_valid: got %h exp %h", rsp.rd_valid, exp);
    end
  endtask

  // Model follows the bus as the DUT samples it
  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `VID_NUM_REGS; i++)
      begin
        gen_mdl[i].raw  = '0;
        tile_mdl[i].raw = '0;
      end
      rd_pending = 1'b0;
      scan_lin   = 0;
    end
    else
    begin
      cycle_cnt++;
      if (gen_mdl[`VID_SYS_CTRL].raw[`VID_RUN_BIT])
        scan_lin = (scan_lin + 1) % FRAME;   // Run bit as it stood before this edge
      rd_pending = host_req.en && host_req.rd;   // Read wins over write
      if (rd_pending)
      begin
        exp_val.push_back(ref_read(host_req.addr));
        exp_chk.push_back(!is_scan_word(host_req.addr));
      end
      else if (host_req.en && host_req.wr && host_req.addr[6:4] == 3'b000)
      begin
        if (host_req.addr[7] && is_rw(1'b1, host_req.addr[3:0]))
          tile_mdl[host_req.addr[3:0]] = merge_bytes(tile_mdl[host_req.addr[3:0]],
                                                     host_req.wdata, host_req.be);
        else if (!host_req.addr[7] && is_rw(1'b0, host_req.addr[3:0]))
          gen_mdl[host_req.addr[3:0]] = merge_bytes(gen_mdl[host_req.addr[3:0]],
                                                    host_req.wdata, host_req.be);
      end
    end
  end

  always @(negedge clk)
  begin : compare
    reg_word_u exp_w;
    bit        chk;
    if (arst_n)
    begin
      check_valid(host_rsp, rd_pending);
      if (host_rsp.rd_valid && exp_val.size() == 0)
      begin
        fail_cnt++;
        $display("Read data returned with no read outstanding");
      end
      else if (host_rsp.rd_valid)
      begin
        exp_w = exp_val.pop_front();
        chk   = exp_chk.pop_front();
        if (chk)
          check_word("rdata", host_rsp.rdata, exp_w);
        else
          cap_q.push_back(host_rsp.rdata);
      end
      if (file_chk_en)
      begin
        check_file("gen_regs", gen_regs, expected_file(1'b0));
        check_file("tile_regs", tile_regs, expected_file(1'b1));
      end
      else
      begin
        // Live scan words against the model position
        exp_w.raw = 16'(scan_lin % `VID_H_TOTAL);
        check_word("gen_regs scan_x", gen_regs[`VID_SCAN_X], exp_w);
        exp_w.raw = 16'(scan_lin / `VID_H_TOTAL);
        check_word("gen_regs scan_y", gen_regs[`VID_SCAN_Y], exp_w);
        exp_w.raw = '0;
        exp_w.raw[`VID_STAT_HBLANK] = (scan_lin % `VID_H_TOTAL) >= `VID_H_ACTIVE;
        exp_w.raw[`VID_STAT_VBLANK] = (scan_lin / `VID_H_TOTAL) >= `VID_V_ACTIVE;
        check_word("gen_regs status", gen_regs[`VID_OUTPUT_STATUS], exp_w);
      end
    end
  end

  task automatic access(input logic en, input logic rd, input logic wr, input logic [1:0] be,
                        input logic [7:0] addr, input logic [15:0] wdata);
    @(posedge clk);
    #2;
    host_req = {en, rd, wr, be, addr, wdata};
  endtask

  task automatic read_word(input logic [7:0] addr);
    access(1'b1, 1'b1, 1'b0, 2'b00, addr, '0);
  endtask

  task automatic write_word(input logic [7:0] addr, input logic [1:0] be, input logic [15:0] d);
    access(1'b1, 1'b0, 1'b1, be, addr, d);
  endtask

  task automatic idle();
    access(1'b0, 1'b0, 1'b0, 2'b00, '0, '0);
  endtask

  task automatic wait_reads_done();
    int n;
    n = 0;
    while ((exp_val.size() != 0 || rd_pending) && n < WAIT_MAX)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_val.size() != 0)
    begin
      fail_cnt++;
      $display("Timed out waiting for read data, %0d reads lost", exp_val.size());
    end
  endtask

  // Reads X, Y and status on three edges and returns the linear position at the X read
  task automatic read_scan(input bit running, output int lin, output int issue_cyc);
    int x;
    int y;
    int lin_st;
    reg_word_u st_exp;
    cap_q.delete();
    read_word({1'b0, 3'b000, 4'(`VID_SCAN_X)});
    issue_cyc = cycle_cnt;
    read_word({1'b0, 3'b000, 4'(`VID_SCAN_Y)});
    read_word({1'b0, 3'b000, 4'(`VID_OUTPUT_STATUS)});
    idle();
    wait_reads_done();
    lin = 0;
    if (cap_q.size() < 3)
    begin
      fail_cnt++;
      $display("Scan read returned %0d of 3 words", cap_q.size());
      return;
    end
    x = cap_q[0].raw;
    y = cap_q[1].raw;
    if (x >= `VID_H_TOTAL || y >= `VID_V_TOTAL)
    begin
      fail_cnt++;
      $display("Scan position %0d,%0d outside the frame", x, y);
    end
    if (running && x == `VID_H_TOTAL - 1)
      y = (y + `VID_V_TOTAL - 1) % `VID_V_TOTAL;   // Line advanced before the Y read
    lin    = y * `VID_H_TOTAL + x;
    lin_st = running ? (lin + 2) % FRAME : lin;
    st_exp.raw = '0;
    st_exp.raw[`VID_STAT_HBLANK] = (lin_st % `VID_H_TOTAL) >= `VID_H_ACTIVE;
    st_exp.raw[`VID_STAT_VBLANK] = (lin_st / `VID_H_TOTAL) >= `VID_V_ACTIVE;
    check_word("status", cap_q[2], st_exp);
  endtask

  task automatic random_rw(input int count);
    logic [15:0] r;
    logic [7:0]  addr;
    logic [15:0] d;
    for (int i = 0; i < count; i++)
    begin
      r    = lcg_next();
      d    = lcg_next();
      addr = {r[0], 3'b000, r[4:1]};
      if (r[7:5] == 3'b000)
        addr[6:4] = r[10:8];   // Now and then unmapped
      if (!addr[7] && addr[3:0] == `VID_SYS_CTRL)
        d[`VID_RUN_BIT] = 1'b0;   // Counter stays stopped
      case (r[13:11])
        3'd0, 3'd1, 3'd2, 3'd3: write_word(addr, r[15:14], d);
        3'd4, 3'd5:             read_word(addr);
        3'd6:                   access(1'b1, 1'b1, 1'b1, r[15:14], addr, d);
        default:                access(1'b0, 1'b1, 1'b1, r[15:14], addr, d);
      endcase
    end
    idle();
    wait_reads_done();
  endtask

  initial
  begin : main
    int lin_a;
    int lin_b;
    int cyc_a;
    int cyc_b;
    host_req = '0;
    arst_n   = 1'b0;
    repeat (16) @(posedge clk);
    #2 arst_n = 1'b1;

    // Every word of both banks after reset
    for (int i = 0; i < `VID_NUM_REGS; i++)
    begin
      read_word({1'b0, 3'b000, 4'(i)});
      read_word({1'b1, 3'b000, 4'(i)});
    end
    idle();
    wait_reads_done();
    read_scan(1'b0, lin_a, cyc_a);
    check_word("scan position", 16'(lin_a), 16'h0000);

    random_rw(400);

    // Read-only, zero and unmapped words ignore writes
    for (int i = 0; i < `VID_NUM_REGS; i++)
    begin
      if (!is_rw(1'b0, 4'(i)))
        write_word({1'b0, 3'b000, 4'(i)}, 2'b11, 16'hFFFF);
      if (!is_rw(1'b1, 4'(i)))
        write_word({1'b1, 3'b000, 4'(i)}, 2'b11, 16'hFFFF);
      write_word({i[0], 3'(i % 7 + 1), 4'(i)}, 2'b11, 16'h5AA5);
      read_word({1'b0, 3'b000, 4'(i)});
      read_word({1'b1, 3'b000, 4'(i)});
      read_word({i[1], 3'(i % 7 + 1), 4'(i)});
    end

    // Read and write together is a read
    write_word({1'b0, 3'b000, 4'(`VID_SCROLL_X)}, 2'b11, 16'h1234);
    access(1'b1, 1'b1, 1'b1, 2'b11, {1'b0, 3'b000, 4'(`VID_SCROLL_X)}, 16'hDEAD);
    read_word({1'b0, 3'b000, 4'(`VID_SCROLL_X)});
    write_word({1'b1, 3'b000, 4'(`VID_TILE_COLOR_KEY)}, 2'b10, 16'hBEEF);
    read_word({1'b1, 3'b000, 4'(`VID_TILE_COLOR_KEY)});
    idle();
    wait_reads_done();

    file_chk_en = 1'b0;   // Scan words move from here on
    write_word({1'b0, 3'b000, 4'(`VID_SYS_CTRL)}, 2'b01, 16'h0001);
    idle();
    for (int i = 0; i < 5; i++)
    begin
      read_scan(1'b1, lin_a, cyc_a);
      repeat (lcg_next() % 1200) idle();
      read_scan(1'b1, lin_b, cyc_b);
      check_word("scan advance", 16'((lin_b - lin_a + FRAME) % FRAME),
                 16'((cyc_b - cyc_a) % FRAME));
    end

    // Clearing run freezes the position
    write_word({1'b0, 3'b000, 4'(`VID_SYS_CTRL)}, 2'b01, 16'h0000);
    idle();
    read_scan(1'b0, lin_a, cyc_a);
    repeat (7) idle();
    read_scan(1'b0, lin_b, cyc_b);
    check_word("scan while stopped", 16'(lin_b), 16'(lin_a));

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/vid_reg_pkg.sv
hdl/vid_bus_pkg.sv
hdl/vid_reg_bank.sv
hdl/vid_scan_counter.sv
hdl/vid_host_port.sv
hdl/vid_regs_top.sv
verif/tb_vid_regs_top.sv

/* Bender.yml */
package:
  name: vid_regs

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vid_reg_pkg.sv
      - hdl/vid_bus_pkg.sv
      - hdl/vid_reg_bank.sv
      - hdl/vid_scan_counter.sv
      - hdl/vid_host_port.sv
      - hdl/vid_regs_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_vid_regs_top.sv
